/* build.f */
source/trace_pkg.sv
source/trace_ctrl_regs.sv
source/trace_packer.sv
source/trace_fifo.sv
source/trace_serializer.sv
source/trace_unit.sv
testbench/trace_unit_props.sv
testbench/trace_unit_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert --timescale 1ns/100ps -Wno-fatal --top-module trace_unit_tb -f build.f &&
./obj_dir/Vtrace_unit_tb | tee /dev/stderr | grep -qx "Done: no errors" &&
echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* source/trace_ctrl_regs.sv */
module trace_ctrl_regs (
    input  logic                  clk,
    input  logic                  reset,
    input  trace_pkg::reg_req_t   reg_req,
    input  logic                  drop,
    output logic [31:0]           reg_rdata,
    output trace_pkg::trace_cfg_t cfg
);

logic [31:0] drop_count;
logic        wr_ctrl;
logic        wr_priv_mask;
logic        wr_kind_mask;
logic        wr_drop_count;

////////////////////////////////////////////////////////////////////////////
// Write decode.
////////////////////////////////////////////////////////////////////////////

assign wr_ctrl       = reg_req.wr && (reg_req.addr == trace_pkg::reg_ctrl);
assign wr_priv_mask  = reg_req.wr && (reg_req.addr == trace_pkg::reg_priv_mask);
assign wr_kind_mask  = reg_req.wr && (reg_req.addr == trace_pkg::reg_kind_mask);
assign wr_drop_count = reg_req.wr && (reg_req.addr == trace_pkg::reg_drop_count);

always_ff @(posedge clk) begin
    if (reset) begin
        cfg.enable    <= 1'b0;
        cfg.priv_mask <= '1;    // Trace every privilege level.
        cfg.kind_mask <= '1;    // And every packet kind.
    end
    else begin
        if (wr_ctrl) begin
            cfg.enable <= reg_req.wdata[0];
        end
        if (wr_priv_mask) begin
            cfg.priv_mask <= reg_req.wdata[3:0];
        end
        if (wr_kind_mask) begin
            cfg.kind_mask <= reg_req.wdata[3:0];
        end
    end
end

// Saturating counter of packets lost to a full FIFO. A write clears it.
always_ff @(posedge clk) begin
    if (reset) begin
        drop_count <= '0;
    end
    else if (wr_drop_count) begin
        drop_count <= '0;
    end
    else if (drop && (drop_count != '1)) begin
        drop_count <= drop_count + 32'd1;
    end
end

////////////////////////////////////////////////////////////////////////////
// Read mux.
////////////////////////////////////////////////////////////////////////////

always_comb begin
    case (reg_req.addr)
        trace_pkg::reg_ctrl: begin
            reg_rdata = {31'd0, cfg.enable};
        end
        trace_pkg::reg_priv_mask: begin
            reg_rdata = {28'd0, cfg.priv_mask};
        end
        trace_pkg::reg_kind_mask: begin
            reg_rdata = {28'd0, cfg.kind_mask};
        end
        default: begin
            reg_rdata = drop_count;
        end
    endcase
end

endmodule

/* source/trace_fifo.sv */
module trace_fifo (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     wr,
    input  trace_pkg::trace_packet_u wdata,
    input  logic                     pop,
    output logic                     empty,
    output trace_pkg::trace_packet_u head,
    output logic                     drop
);

trace_pkg::trace_packet_u mem [trace_pkg::fifo_depth];

logic [trace_pkg::fifo_ptr_bits-1:0] rd_ptr;
logic [trace_pkg::fifo_ptr_bits-1:0] wr_ptr;
logic [trace_pkg::fifo_ptr_bits:0]   count;
logic                                full;
logic                                push;
logic                                take;

assign full  = (count == trace_pkg::fifo_depth);
assign empty = (count == '0);

// A pop at the same edge frees the slot for an incoming write.
assign push = wr && (!full || pop);
assign take = pop && !empty;
assign drop = wr && full && !pop;

assign head = mem[rd_ptr];    // Oldest entry, shown ahead.

always_ff @(posedge clk) begin
    if (push) begin
        mem[wr_ptr] <= wdata;
    end
end

////////////////////////////////////////////////////////////////////////////
// Pointers and fill level.
////////////////////////////////////////////////////////////////////////////

always_ff @(posedge clk) begin
    if (reset) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
    end
    else begin
        if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
        if (take) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        count <= '0;
    end
    else begin
        case ({push, take})
            2'b10: begin
                count <= count + 1'b1;
            end
            2'b01: begin
                count <= count - 1'b1;
            end
            default: begin
                count <= count;    // Both or neither.
            end
        endcase
    end
end

endmodule

/* source/trace_packer.sv */
module trace_packer (
    input  logic                     clk,
    input  logic                     reset,
    input  trace_pkg::retire_info_t  retire,
    input  trace_pkg::trap_info_t    trap,
    input  trace_pkg::trace_cfg_t    cfg,
    output logic                     pkt_wr,
    output trace_pkg::trace_packet_u pkt
);

logic [1:0]               kind;
logic                     fire;
logic                     keep;
trace_pkg::packet_head_t  head;
trace_pkg::trace_packet_u pkt_d;

// A trap wins over a retire in the same cycle.
always_comb begin
    if (trap.trap_en) begin
        kind = trace_pkg::kind_trap;
    end
    else if (retire.mem_req && retire.mem_wr) begin
        kind = trace_pkg::kind_store;
    end
    else if (retire.mem_req) begin
        kind = trace_pkg::kind_load;
    end
    else begin
        kind = trace_pkg::kind_retire;
    end
end

assign head.kind   = kind;
assign head.prv    = retire.prv;
assign head.xlen64 = retire.xlen64;
assign head.cycle  = retire.cycle;

always_comb begin
    case (kind)
        trace_pkg::kind_store, trace_pkg::kind_load: begin
            pkt_d.mem.head     = head;
            pkt_d.mem.pc       = retire.pc;
            pkt_d.mem.insn     = retire.insn;
            pkt_d.mem.mem_addr = retire.mem_addr;
            pkt_d.mem.mem_data = retire.mem_wr ? retire.mem_wdata : retire.mem_rdata;
        end
        trace_pkg::kind_trap: begin
            pkt_d.trap.head   = head;
            pkt_d.trap.epc    = trap.epc;
            pkt_d.trap.insn   = 32'd0;
            pkt_d.trap.mcause = trap.mcause;
            pkt_d.trap.mtval  = trap.mtval;
        end
        default: begin
            pkt_d.regs.head      = head;
            pkt_d.regs.pc        = retire.pc;
            pkt_d.regs.insn      = retire.insn;
            pkt_d.regs.csr_wdata = retire.csr_wdata;
            pkt_d.regs.rd_data   = retire.rd_data;
        end
    endcase
end

assign fire = cfg.enable && (trap.trap_en || retire.valid);
assign keep = fire && cfg.priv_mask[retire.prv] && cfg.kind_mask[kind];

always_ff @(posedge clk) begin
    if (reset) begin
        pkt_wr <= 1'b0;
    end
    else begin
        pkt_wr <= keep;
    end
end

always_ff @(posedge clk) begin
    if (keep) begin
        pkt <= pkt_d;
    end
end

endmodule

/* source/trace_pkg.sv */
package trace_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sizes.
    ////////////////////////////////////////////////////////////////////////////

    localparam int xlen             = 64;
    localparam int packet_width     = 256;
    localparam int beat_width       = 64;
    localparam int beats_per_packet = packet_width / beat_width;
    localparam int beat_idx_bits    = $clog2(beats_per_packet);
    localparam int fifo_depth       = 4;
    localparam int fifo_ptr_bits    = $clog2(fifo_depth);
    localparam int cycle_bits       = 27;

    // Packet kinds, as carried in the top two bits of a packet.
    localparam logic [1:0] kind_store  = 2'd0;
    localparam logic [1:0] kind_load   = 2'd1;
    localparam logic [1:0] kind_retire = 2'd2;
    localparam logic [1:0] kind_trap   = 2'd3;

    // Register map.
    localparam logic [1:0] reg_ctrl       = 2'd0;
    localparam logic [1:0] reg_priv_mask  = 2'd1;
    localparam logic [1:0] reg_kind_mask  = 2'd2;
    localparam logic [1:0] reg_drop_count = 2'd3;

    ////////////////////////////////////////////////////////////////////////////
    // Core side.
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                  valid;
        logic [1:0]            prv;
        logic                  xlen64;
        logic [cycle_bits-1:0] cycle;
        logic [xlen-1:0]       pc;
        logic [31:0]           insn;
        logic                  mem_req;
        logic                  mem_wr;
        logic [xlen-1:0]       mem_addr;
        logic [xlen-1:0]       mem_rdata;
        logic [xlen-1:0]       mem_wdata;
        logic [xlen-1:0]       csr_wdata;
        logic [xlen-1:0]       rd_data;
    } retire_info_t;

    typedef struct packed {
        logic            trap_en;
        logic [xlen-1:0] epc;
        logic [xlen-1:0] mcause;
        logic [xlen-1:0] mtval;
    } trap_info_t;

    ////////////////////////////////////////////////////////////////////////////
    // Packet.
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [1:0]            kind;
        logic [1:0]            prv;
        logic                  xlen64;
        logic [cycle_bits-1:0] cycle;
    } packet_head_t;

    typedef struct packed {
        packet_head_t    head;
        logic [xlen-1:0] pc;
        logic [31:0]     insn;
        logic [xlen-1:0] mem_addr;
        logic [xlen-1:0] mem_data;    // Rdata on loads, wdata on stores.
    } packet_mem_t;

    typedef struct packed {
        packet_head_t    head;
        logic [xlen-1:0] pc;
        logic [31:0]     insn;
        logic [xlen-1:0] csr_wdata;
        logic [xlen-1:0] rd_data;
    } packet_reg_t;

    typedef struct packed {
        packet_head_t    head;
        logic [xlen-1:0] epc;
        logic [31:0]     insn;        // Always zero.
        logic [xlen-1:0] mcause;
        logic [xlen-1:0] mtval;
    } packet_trap_t;

    // The kind field in the head picks the view.
    typedef union packed {
        packet_mem_t  mem;
        packet_reg_t  regs;
        packet_trap_t trap;
    } trace_packet_u;

    ////////////////////////////////////////////////////////////////////////////
    // Configuration.
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic       enable;
        logic [3:0] priv_mask;
        logic [3:0] kind_mask;
    } trace_cfg_t;

    typedef struct packed {
        logic        wr;
        logic [1:0]  addr;
        logic [31:0] wdata;
    } reg_req_t;

endpackage

/* source/trace_serializer.sv */
module trace_serializer (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             empty,
    input  trace_pkg::trace_packet_u         head,
    input  logic                             stall,
    output logic                             pop,
    output logic                             beat_valid,
    output logic [trace_pkg::beat_width-1:0] beat_data,
    output logic                             beat_last
);

localparam logic [trace_pkg::beat_idx_bits-1:0] last_idx =
    trace_pkg::beat_idx_bits'(trace_pkg::beats_per_packet - 1);

// Word 0 is bits 63:0 of the packet and leaves first.
logic [trace_pkg::beats_per_packet-1:0][trace_pkg::beat_width-1:0] words;
logic [trace_pkg::beat_idx_bits-1:0]                               idx;
logic                                                              holding;
logic                                                              last;

assign last = holding && (idx == last_idx);

// Reload when idle, or as the final beat leaves, so packets run back to back.
assign pop = !empty && (!holding || (last && !stall));

always_ff @(posedge clk) begin
    if (reset) begin
        holding <= 1'b0;
        idx     <= '0;
    end
    else if (pop) begin
        holding <= 1'b1;
        idx     <= '0;
    end
    else if (holding && !stall) begin
        if (last) begin
            holding <= 1'b0;
        end
        idx <= idx + 1'b1;    // Wraps to zero after the last word.
    end
end

always_ff @(posedge clk) begin
    if (pop) begin
        words <= head;
    end
end

////////////////////////////////////////////////////////////////////////////
// Beat output.
////////////////////////////////////////////////////////////////////////////

assign beat_valid = holding;
assign beat_data  = words[idx];
assign beat_last  = last;

endmodule

/* source/trace_unit.sv */
module trace_unit (
    input  logic                             clk,
    input  logic                             reset,
    input  trace_pkg::retire_info_t          retire,
    input  trace_pkg::trap_info_t            trap,
    input  trace_pkg::reg_req_t              reg_req,
    output logic [31:0]                      reg_rdata,
    input  logic                             stall,
    output logic                             beat_valid,
    output logic [trace_pkg::beat_width-1:0] beat_data,
    output logic                             beat_last
);

trace_pkg::trace_cfg_t    cfg;
logic                     pkt_wr;
trace_pkg::trace_packet_u pkt;
logic                     drop;
logic                     empty;
trace_pkg::trace_packet_u head;
logic                     pop;

trace_ctrl_regs trace_ctrl_regs_i (
    .clk       (clk),
    .reset     (reset),
    .reg_req   (reg_req),
    .drop      (drop),
    .reg_rdata (reg_rdata),
    .cfg       (cfg)
);

trace_packer trace_packer_i (
    .clk    (clk),
    .reset  (reset),
    .retire (retire),
    .trap   (trap),
    .cfg    (cfg),
    .pkt_wr (pkt_wr),
    .pkt    (pkt)
);

trace_fifo trace_fifo_i (
    .clk   (clk),
    .reset (reset),
    .wr    (pkt_wr),
    .wdata (pkt),
    .pop   (pop),
    .empty (empty),
    .head  (head),
    .drop  (drop)
);

trace_serializer trace_serializer_i (
    .clk        (clk),
    .reset      (reset),
    .empty      (empty),
    .head       (head),
    .stall      (stall),
    .pop        (pop),
    .beat_valid (beat_valid),
    .beat_data  (beat_data),
    .beat_last  (beat_last)
);

endmodule

/* testbench/trace_unit_props.sv */
module trace_unit_props (
    input logic        clk,
    input logic        reset,
    input logic        stall,
    input logic        beat_valid,
    input logic [63:0] beat_data,
    input logic        beat_last,
    input logic        pkt_wr,
    input logic        drop,
    input logic        pop,
    input logic        empty
);

timeunit 1ns;
timeprecision 100ps;

logic [1:0] beats_seen;    // Advancing beats, modulo four.
logic [2:0] entries;       // FIFO fill level, rebuilt from its write and pop traffic.

always_ff @(posedge clk) begin
    if (reset) begin
        beats_seen <= '0;
    end
    else if (beat_valid && !stall) begin
        beats_seen <= beats_seen + 2'd1;
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        entries <= '0;
    end
    else begin
        entries <= entries + {2'd0, pkt_wr && !drop} - {2'd0, pop};
    end
end

hold_under_stall: assert property (@(posedge clk) disable iff (reset)
    beat_valid && stall |=> $stable(beat_data) && $stable(beat_last))
    else $error("Beat data or beat_last moved while stalled.");

idle_in_reset: assert property (@(posedge clk) reset |=> !beat_valid)
    else $error("beat_valid high after a reset edge.");

last_every_fourth: assert property (@(posedge clk) disable iff (reset)
    beat_valid && !stall |-> beat_last == (beats_seen == 2'd3))
    else $error("beat_last out of step with the beat count.");

pop_needs_entry: assert property (@(posedge clk) disable iff (reset)
    entries == '0 |-> empty && !pop)
    else $error("Pop or a shown entry while nothing is left in the FIFO.");

endmodule

/* testbench/trace_unit_tb.sv */
module trace_unit_tb;

timeunit 1ns;
timeprecision 100ps;

localparam int max_cycles = 4000;    // Phases run about 2500 cycles together.

logic                    clk;
logic                    reset;
trace_pkg::retire_info_t retire;
trace_pkg::trap_info_t   trap;
trace_pkg::reg_req_t     reg_req;
logic [31:0]             reg_rdata;
logic                    stall;
logic                    beat_valid;
logic [63:0]             beat_data;
logic                    beat_last;

logic [255:0] exp_q[$];    // Model packets, oldest first.
logic [255:0] cur_pkt;
bit           enable_m;
logic [3:0]   priv_m = '1;
logic [3:0]   kind_m = '1;
int           stall_pct = 10;
int           held_count;
int           exp_drops;
int           packets;
int           beats;
int           beat_idx;
int           errors;
int           cycles;

trace_unit trace_unit_i (.*);

bind trace_unit trace_unit_props trace_unit_props_i (.*);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
        $display("Timeout after %0d cycles, %0d packets never left", cycles, exp_q.size());
        $display("Errors: %0d, packets: %0d", errors, packets);
        $display("Done: errors found");
        $finish;
    end
end

////////////////////////////////////////////////////////////////////////////
// Stimulus and model.
////////////////////////////////////////////////////////////////////////////

// One cycle of random core activity, and what the model expects from it.
task automatic drive_cycle(input bit active);
    logic [671:0]            rnd;
    trace_pkg::retire_info_t r;
    trace_pkg::trap_info_t   t;
    logic [1:0]              kind;
    logic [31:0]             head;
    for (int i = 0; i < 21; i++) begin
        rnd[i*32 +: 32] = $urandom;
    end
    r = rnd[448:0];
    t = rnd[641:449];
    active = active && (stall_pct == 10 || exp_q.size() < 3);    // FIFO stays short of full.
    r.valid   = active && ($urandom % 10 < 6);
    t.trap_en = active && ($urandom % 10 < 2);
    @(posedge clk);
    retire     <= r;
    trap       <= t;
    reg_req.wr <= 1'b0;
    stall      <= ($urandom % 10) < stall_pct;
    kind = t.trap_en ? trace_pkg::kind_trap
         : !r.mem_req ? trace_pkg::kind_retire
         : r.mem_wr ? trace_pkg::kind_store : trace_pkg::kind_load;
    head = {kind, r.prv, r.xlen64, r.cycle};
    if (!enable_m || !(r.valid || t.trap_en) || !priv_m[r.prv] || !kind_m[kind]) begin
        return;
    end
    held_count += (stall_pct == 10);
    if (stall_pct == 10 && held_count > 5) begin
        exp_drops++;    // Serializer holds one, the FIFO four.
        return;
    end
    packets++;
    case (kind)
        trace_pkg::kind_trap:  exp_q.push_back({head, t.epc, 32'd0, t.mcause, t.mtval});
        trace_pkg::kind_store: exp_q.push_back({head, r.pc, r.insn, r.mem_addr, r.mem_wdata});
        trace_pkg::kind_load:  exp_q.push_back({head, r.pc, r.insn, r.mem_addr, r.mem_rdata});
        default:               exp_q.push_back({head, r.pc, r.insn, r.csr_wdata, r.rd_data});
    endcase
endtask

// Register write or read with the core quiet.
task automatic reg_access(input bit write, input logic [1:0] addr, input logic [31:0] data);
    @(posedge clk);
    retire.valid <= 1'b0;
    trap.trap_en <= 1'b0;
    reg_req      <= {write, addr, data};
    @(negedge clk);
    if (write) begin
        case (addr)
            trace_pkg::reg_ctrl:      enable_m  = data[0];
            trace_pkg::reg_priv_mask: priv_m    = data[3:0];
            trace_pkg::reg_kind_mask: kind_m    = data[3:0];
            default:                  exp_drops = 0;
        endcase
    end
    else if (reg_rdata !== data) begin
        $display("Error: reg_rdata at %h is %h, expected %h", addr, reg_rdata, data);
        errors++;
    end
endtask

task automatic drain();
    stall_pct = 0;
    while (exp_q.size() != 0 || beat_idx != 0) drive_cycle(1'b0);
    repeat (8) drive_cycle(1'b0);
endtask

// A beat leaves at the next edge when it is valid and not stalled.
always @(negedge clk) begin
    if (!reset && beat_valid && !stall) begin
        if (beat_idx == 0 && exp_q.size() == 0) begin
            $display("Unexpected beat: a packet left that the model never formed");
            errors++;
            cur_pkt = '0;
        end
        else if (beat_idx == 0) begin
            cur_pkt = exp_q.pop_front();
        end
        if (beat_data !== cur_pkt[beat_idx*64 +: 64]) begin
            $display("Error: beat_data is %h, expected %h",
                     beat_data, cur_pkt[beat_idx*64 +: 64]);
            errors++;
        end
        if (beat_last !== (beat_idx == 3)) begin
            $display("Error: beat_last is %h, expected %h", beat_last, beat_idx == 3);
            errors++;
        end
        beat_idx = (beat_idx + 1) % 4;
        beats++;
    end
end

initial begin
    void'($urandom(93283));
    reset   = 1'b1;
    stall   = 1'b1;
    retire  = '0;
    trap    = '0;
    reg_req = '0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    // Capacity with stall held since reset.
    reg_access(1'b1, trace_pkg::reg_ctrl, 32'd1);
    while (held_count < 8) drive_cycle(1'b1);
    repeat (4) drive_cycle(1'b0);
    reg_access(1'b0, trace_pkg::reg_drop_count, 32'(exp_drops));
    drain();
    reg_access(1'b1, trace_pkg::reg_drop_count, 32'd0);
    reg_access(1'b0, trace_pkg::reg_drop_count, 32'd0);
    repeat (600) drive_cycle(1'b1);    // All kinds, traps over retires.
    repeat (3) begin
        reg_access(1'b1, trace_pkg::reg_priv_mask, $urandom % 16);
        reg_access(1'b1, trace_pkg::reg_kind_mask, $urandom % 16);
        reg_access(1'b0, trace_pkg::reg_priv_mask, 32'(priv_m));
        reg_access(1'b0, trace_pkg::reg_kind_mask, 32'(kind_m));
        repeat (200) drive_cycle(1'b1);
    end
    reg_access(1'b1, trace_pkg::reg_ctrl, 32'd0);
    repeat (100) drive_cycle(1'b1);
    reg_access(1'b1, trace_pkg::reg_ctrl, 32'd1);
    reg_access(1'b1, trace_pkg::reg_priv_mask, 32'hf);
    reg_access(1'b1, trace_pkg::reg_kind_mask, 32'hf);
    stall_pct = 3;
    repeat (800) drive_cycle(1'b1);
    drain();
    if (beats != 4 * packets) begin
        $display("Beat count wrong: %0d beats for %0d packets", beats, packets);
        errors++;
    end
    $display("Errors: %0d, packets: %0d", errors, packets);
    if (errors == 0) begin
        $display("Done: no errors");
    end
    else begin
        $display("Done: errors found");
    end
    $finish;
end

endmodule
